//--- filelist.f
+incdir+test
common/soc_pkg.sv
devices/uart_console.sv
devices/intc.sv
rtl/device_arbiter.sv
rtl/device_decoder.sv
rtl/device_subsystem.sv
test/tb_device_subsystem.sv

//--- run.sh
#!/bin/sh
# Build and run the device subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_device_subsystem -f filelist.f

out=$(./obj_dir/Vtb_device_subsystem)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

//--- test/tb_tasks.svh
// ----------------------------------------------------------------------------
// Register addresses
// ----------------------------------------------------------------------------
localparam addr_t UART_BASE    = {IO_WINDOW, 2'b00, DEV_UART, 24'h0};
localparam addr_t INTC_BASE    = {IO_WINDOW, 2'b00, DEV_INTC, 24'h0};
localparam addr_t UART_TX      = UART_BASE + addr_t'({REG_TX, 2'b00});
localparam addr_t UART_STATUS  = UART_BASE + addr_t'({REG_STATUS, 2'b00});
localparam addr_t UART_SIMDONE = UART_BASE + addr_t'({REG_SIMDONE, 2'b00});
localparam addr_t INTC_PENDING = INTC_BASE + addr_t'({REG_PENDING, 2'b00});
localparam addr_t INTC_ENABLE  = INTC_BASE + addr_t'({REG_ENABLE, 2'b00});
localparam data_t IRQ_MASK     = data_t'({IRQ_LINES{1'b1}});

task automatic console_tx_write();
    data_t rd;
    int cyc;
    $display("Console transmit from core 0");
    tx_log.delete();
    bus_access(1'b0, 1'b1, UART_TX, 4'b0001, 32'h0000_0041, rd, cyc);
    if (cyc != 3) report_mismatch("core_ready_o latency", data_t'(cyc), 32'd3);
    if (tx_log.size() != 1) begin
        report_mismatch("tx_valid_o pulses", data_t'(tx_log.size()), 32'd1);
    end else if (tx_log[0] !== 8'h41) begin
        report_mismatch("tx_data_o", data_t'(tx_log[0]), 32'h41);
    end
    // Lane 0 disabled so nothing goes out
    bus_access(1'b0, 1'b1, UART_TX, 4'b1110, 32'h0000_005a, rd, cyc);
    if (tx_log.size() != 1) report_mismatch("tx_valid_o pulses", data_t'(tx_log.size()), 32'd1);
endtask

task automatic intc_enable_pending();
    data_t rd;
    int cyc;
    $display("Interrupt controller from core 1");
    bus_access(1'b1, 1'b1, INTC_ENABLE, 4'hf, 32'h0000_0005, rd, cyc);
    bus_access(1'b1, 1'b0, INTC_ENABLE, 4'hf, '0, rd, cyc);
    if (rd !== 32'h5) report_mismatch("enable readback", rd, 32'h5);

    // Line 1 is not enabled
    irq_src = 4'b0010;
    repeat (2) @(negedge clk);
    bus_access(1'b1, 1'b0, INTC_PENDING, 4'hf, '0, rd, cyc);
    if (rd !== 32'h2) report_mismatch("pending readback", rd, 32'h2);
    if (irq_o !== 1'b0) report_mismatch("irq_o", data_t'(irq_o), '0);

    irq_src = 4'b0110;
    repeat (2) @(negedge clk);
    bus_access(1'b1, 1'b0, INTC_PENDING, 4'hf, '0, rd, cyc);
    if (rd !== 32'h6) report_mismatch("pending readback", rd, 32'h6);
    if (irq_o !== 1'b1) report_mismatch("irq_o", data_t'(irq_o), 32'h1);

    irq_src = '0;
    bus_access(1'b1, 1'b1, INTC_PENDING, 4'hf, 32'h0000_0006, rd, cyc);
    if (irq_o !== 1'b0) report_mismatch("irq_o", data_t'(irq_o), '0);
    bus_access(1'b1, 1'b0, INTC_PENDING, 4'hf, '0, rd, cyc);
    if (rd !== 32'h0) report_mismatch("pending readback", rd, '0);
endtask

task automatic zero_reads();
    data_t rd;
    int cyc;
    addr_t addrs [3];
    $display("Status and unmapped reads");
    addrs[0] = UART_STATUS;
    addrs[1] = 32'hc200_0010;
    addrs[2] = 32'h4000_0000;
    // Nonzero data sits in the read path before each zero read
    bus_access(1'b0, 1'b1, INTC_ENABLE, 4'hf, 32'h0000_000a, rd, cyc);
    for (int i = 0; i < 3; i++) begin
        bus_access(1'b0, 1'b0, INTC_ENABLE, 4'hf, '0, rd, cyc);
        if (rd !== 32'ha) report_mismatch("enable readback", rd, 32'ha);
        bus_access(1'b0, 1'b0, addrs[i], 4'hf, '0, rd, cyc);
        if (rd !== 32'h0) report_mismatch("core_rdata_o", rd, '0);
        if (cyc != 3) report_mismatch("core_ready_o latency", data_t'(cyc), 32'd3);
    end
endtask

task automatic two_core_tx();
    data_t rd0;
    data_t rd1;
    int cyc0;
    int cyc1;
    $display("Console writes from both cores at once");
    tx_log.delete();
    fork
        bus_access(1'b0, 1'b1, UART_TX, 4'b0001, 32'h0000_0030, rd0, cyc0);
        bus_access(1'b1, 1'b1, UART_TX, 4'b0001, 32'h0000_0031, rd1, cyc1);
    join
    if (tx_log.size() != 2) begin
        report_mismatch("tx_valid_o pulses", data_t'(tx_log.size()), 32'd2);
    end else begin
        if (tx_log[0] !== 8'h30) report_mismatch("tx_data_o first", data_t'(tx_log[0]), 32'h30);
        if (tx_log[1] !== 8'h31) report_mismatch("tx_data_o second", data_t'(tx_log[1]), 32'h31);
    end
endtask

task automatic random_enable_rw();
    data_t rd;
    data_t wval;
    core_id_t wcore;
    core_id_t rcore;
    int cyc;
    $display("Random enable writes and readback");
    for (int n = 0; n < 20; n++) begin
        wcore = core_id_t'($urandom % NUM_CORES);
        rcore = core_id_t'($urandom % NUM_CORES);
        wval = $urandom;
        bus_access(wcore, 1'b1, INTC_ENABLE, 4'hf, wval, rd, cyc);
        bus_access(rcore, 1'b0, INTC_ENABLE, 4'hf, '0, rd, cyc);
        if (rd !== (wval & IRQ_MASK)) report_mismatch("enable readback", rd, wval & IRQ_MASK);
    end
endtask

task automatic sim_done_flag();
    data_t rd;
    int cyc;
    $display("Simulation done flag");
    if (sim_done_o !== 1'b0) report_mismatch("sim_done_o", data_t'(sim_done_o), '0);
    bus_access(1'b0, 1'b1, UART_SIMDONE, 4'hf, 32'h0000_0001, rd, cyc);
    if (sim_done_o !== 1'b1) report_mismatch("sim_done_o", data_t'(sim_done_o), 32'h1);
    // Sticky across later traffic
    bus_access(1'b1, 1'b0, UART_STATUS, 4'hf, '0, rd, cyc);
    repeat (10) @(negedge clk);
    if (sim_done_o !== 1'b1) report_mismatch("sim_done_o", data_t'(sim_done_o), 32'h1);
endtask

//--- test/tb_device_subsystem.sv
`timescale 1ns/1ps

module tb_device_subsystem;
    import soc_pkg::*;

    localparam int HALF_PERIOD = 2;
    localparam int RESET_CYCLES = 8;
    // Roughly 60 requests of under 10 cycles each plus a wide margin
    localparam int WATCHDOG_CYCLES = 5000;
    localparam int ACCESS_TIMEOUT = 40;
    localparam logic [31:0] SEED = 32'h1aba;

    logic  clk;
    logic  reset_i;
    logic  core_strobe [NUM_CORES];
    logic  core_we     [NUM_CORES];
    addr_t core_addr   [NUM_CORES];
    be_t   core_be     [NUM_CORES];
    data_t core_wdata  [NUM_CORES];
    logic  core_ready  [NUM_CORES];
    data_t core_rdata  [NUM_CORES];
    irq_t  irq_src;
    logic  irq_o;
    logic  tx_valid_o;
    logic  [7:0] tx_data_o;
    logic  sim_done_o;

    int mismatch_count;
    int problem_count;

    // Bytes seen on the console output in order
    logic [7:0] tx_log [$];

    device_subsystem dut0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .core_strobe_i(core_strobe),
        .core_we_i    (core_we),
        .core_addr_i  (core_addr),
        .core_be_i    (core_be),
        .core_wdata_i (core_wdata),
        .core_ready_o (core_ready),
        .core_rdata_o (core_rdata),
        .irq_src_i    (irq_src),
        .irq_o        (irq_o),
        .tx_valid_o   (tx_valid_o),
        .tx_data_o    (tx_data_o),
        .sim_done_o   (sim_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    always @(negedge clk) begin
        if (tx_valid_o === 1'b1) begin
            tx_log.push_back(tx_data_o);
        end
    end

    // ------------------------------------------------------------------------
    // Reporting and bus access
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string name, input data_t got, input data_t exp);
        mismatch_count++;
        $display("[FAIL] %0t ns: %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic report_problem(input string msg);
        problem_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // One request from a core; cycles counts falling edges until its ready
    task automatic bus_access(input core_id_t core, input logic we, input addr_t addr,
                              input be_t be, input data_t wdata,
                              output data_t rdata, output int cycles);
        logic got_ready;
        got_ready = 1'b0;
        cycles = 0;
        rdata = '0;
        @(negedge clk);
        core_strobe[core] = 1'b1;
        core_we[core]     = we;
        core_addr[core]   = addr;
        core_be[core]     = be;
        core_wdata[core]  = wdata;
        while (!got_ready && cycles < ACCESS_TIMEOUT) begin
            @(negedge clk);
            core_strobe[core] = 1'b0;
            cycles++;
            if (core_ready[core] === 1'b1) begin
                got_ready = 1'b1;
                rdata = core_rdata[core];
            end
        end
        if (!got_ready) begin
            report_problem($sformatf("core %0d never got ready for address %h", core, addr));
        end
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < NUM_CORES; i++) begin
            if (core_ready[i] !== 1'b0) begin
                report_mismatch("core_ready_o", data_t'(core_ready[i]), '0);
            end
        end
        if (tx_valid_o !== 1'b0) report_mismatch("tx_valid_o", data_t'(tx_valid_o), '0);
        if (sim_done_o !== 1'b0) report_mismatch("sim_done_o", data_t'(sim_done_o), '0);
        if (irq_o !== 1'b0) report_mismatch("irq_o", data_t'(irq_o), '0);
    endtask

    `include "tb_tasks.svh"

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int seed_val;
        mismatch_count = 0;
        problem_count = 0;
        seed_val = $urandom(SEED);
        reset_i = 1'b1;
        irq_src = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            core_strobe[i] = 1'b0;
            core_we[i]     = 1'b0;
            core_addr[i]   = '0;
            core_be[i]     = '0;
            core_wdata[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_reset_state();

        // Core 0 holds priority only while no grant has happened since reset
        two_core_tx();
        console_tx_write();
        intc_enable_pending();
        zero_reads();
        random_enable_rw();
        sim_done_flag();

        $display("Value errors: %0d, other errors: %0d", mismatch_count, problem_count);
        if (mismatch_count == 0 && problem_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- rtl/device_subsystem.sv
`timescale 1ns/1ps

module device_subsystem (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           core_strobe_i [soc_pkg::NUM_CORES],
    input  logic           core_we_i     [soc_pkg::NUM_CORES],
    input  soc_pkg::addr_t core_addr_i   [soc_pkg::NUM_CORES],
    input  soc_pkg::be_t   core_be_i     [soc_pkg::NUM_CORES],
    input  soc_pkg::data_t core_wdata_i  [soc_pkg::NUM_CORES],
    output logic           core_ready_o  [soc_pkg::NUM_CORES],
    output soc_pkg::data_t core_rdata_o  [soc_pkg::NUM_CORES],
    input  soc_pkg::irq_t  irq_src_i,
    output logic           irq_o,
    output logic           tx_valid_o,
    output logic [7:0]     tx_data_o,
    output logic           sim_done_o
);
    import soc_pkg::*;

    // Arbitrated device bus
    logic  dev_strobe;
    logic  dev_we;
    addr_t dev_addr;
    be_t   dev_be;
    data_t dev_wdata;
    logic  dev_ready;
    data_t dev_rdata;

    // Per-device returns
    logic  uart_strobe;
    logic  uart_ready;
    data_t uart_rdata;
    logic  intc_strobe;
    logic  intc_ready;
    data_t intc_rdata;

    device_arbiter arb0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .core_strobe_i(core_strobe_i),
        .core_we_i    (core_we_i),
        .core_addr_i  (core_addr_i),
        .core_be_i    (core_be_i),
        .core_wdata_i (core_wdata_i),
        .core_ready_o (core_ready_o),
        .core_rdata_o (core_rdata_o),
        .dev_strobe_o (dev_strobe),
        .dev_we_o     (dev_we),
        .dev_addr_o   (dev_addr),
        .dev_be_o     (dev_be),
        .dev_wdata_o  (dev_wdata),
        .dev_ready_i  (dev_ready),
        .dev_rdata_i  (dev_rdata)
    );

    device_decoder dec0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_strobe_i (dev_strobe),
        .bus_addr_i   (dev_addr),
        .bus_ready_o  (dev_ready),
        .bus_rdata_o  (dev_rdata),
        .uart_strobe_o(uart_strobe),
        .uart_ready_i (uart_ready),
        .uart_rdata_i (uart_rdata),
        .intc_strobe_o(intc_strobe),
        .intc_ready_i (intc_ready),
        .intc_rdata_i (intc_rdata)
    );

    // Register offset is the word index in bits 3:2
    uart_console uart0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .strobe_i  (uart_strobe),
        .we_i      (dev_we),
        .reg_sel_i (dev_addr[3:2]),
        .be_i      (dev_be),
        .wdata_i   (dev_wdata),
        .ready_o   (uart_ready),
        .rdata_o   (uart_rdata),
        .tx_valid_o(tx_valid_o),
        .tx_data_o (tx_data_o),
        .sim_done_o(sim_done_o)
    );

    intc intc0 (
        .clk      (clk),
        .reset_i  (reset_i),
        .strobe_i (intc_strobe),
        .we_i     (dev_we),
        .reg_sel_i(dev_addr[3:2]),
        .be_i     (dev_be),
        .wdata_i  (dev_wdata),
        .ready_o  (intc_ready),
        .rdata_o  (intc_rdata),
        .irq_src_i(irq_src_i),
        .irq_o    (irq_o)
    );

endmodule

//--- rtl/device_decoder.sv
`timescale 1ns/1ps

module device_decoder (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           bus_strobe_i,
    input  soc_pkg::addr_t bus_addr_i,
    output logic           bus_ready_o,
    output soc_pkg::data_t bus_rdata_o,
    output logic           uart_strobe_o,
    input  logic           uart_ready_i,
    input  soc_pkg::data_t uart_rdata_i,
    output logic           intc_strobe_o,
    input  logic           intc_ready_i,
    input  soc_pkg::data_t intc_rdata_i
);
    import soc_pkg::*;

    logic in_window;
    logic sel_uart;
    logic sel_intc;
    logic unmapped_ready_q;

    // Address is held by the arbiter until ready, so one decode serves both ways
    assign in_window = (bus_addr_i[XLEN-1:XLEN-2] == IO_WINDOW);
    assign sel_uart  = in_window && (bus_addr_i[27:24] == DEV_UART);
    assign sel_intc  = in_window && (bus_addr_i[27:24] == DEV_INTC);

    assign uart_strobe_o = bus_strobe_i && sel_uart;
    assign intc_strobe_o = bus_strobe_i && sel_intc;

    // Unmapped access answers on its own one cycle later
    always_ff @(posedge clk) begin
        if (reset_i) begin
            unmapped_ready_q <= 1'b0;
        end else begin
            unmapped_ready_q <= bus_strobe_i && !sel_uart && !sel_intc;
        end
    end

    assign bus_ready_o = (sel_uart && uart_ready_i) ||
                         (sel_intc && intc_ready_i) ||
                         unmapped_ready_q;

    always_comb begin
        if (sel_uart) begin
            bus_rdata_o = uart_rdata_i;
        end else if (sel_intc) begin
            bus_rdata_o = intc_rdata_i;
        end else begin
            bus_rdata_o = '0;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({uart_strobe_o, intc_strobe_o}));

    // Every device path, selected or not, completes in the next cycle
    a_fixed_latency: assert property (@(posedge clk) disable iff (reset_i)
        bus_strobe_i |=> bus_ready_o);

endmodule

//--- rtl/device_arbiter.sv
`timescale 1ns/1ps

module device_arbiter (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           core_strobe_i [soc_pkg::NUM_CORES],
    input  logic           core_we_i     [soc_pkg::NUM_CORES],
    input  soc_pkg::addr_t core_addr_i   [soc_pkg::NUM_CORES],
    input  soc_pkg::be_t   core_be_i     [soc_pkg::NUM_CORES],
    input  soc_pkg::data_t core_wdata_i  [soc_pkg::NUM_CORES],
    output logic           core_ready_o  [soc_pkg::NUM_CORES],
    output soc_pkg::data_t core_rdata_o  [soc_pkg::NUM_CORES],
    output logic           dev_strobe_o,
    output logic           dev_we_o,
    output soc_pkg::addr_t dev_addr_o,
    output soc_pkg::be_t   dev_be_o,
    output soc_pkg::data_t dev_wdata_o,
    input  logic           dev_ready_i,
    input  soc_pkg::data_t dev_rdata_i
);
    import soc_pkg::*;

    arb_state_t           state_q;
    logic [NUM_CORES-1:0] pending_q;
    core_id_t             rr_ptr_q;
    core_id_t             cur_id_q;

    // Latched request fields per core
    logic                 req_we_q    [NUM_CORES];
    addr_t                req_addr_q  [NUM_CORES];
    be_t                  req_be_q    [NUM_CORES];
    data_t                req_wdata_q [NUM_CORES];

    logic [NUM_CORES-1:0] cand;
    logic                 grant_valid;
    logic                 grant;
    core_id_t             grant_id;
    core_id_t             next_ptr;
    logic                 done;

    // ------------------------------------------------------------------------
    // Round-robin selection
    // ------------------------------------------------------------------------

    // A strobe arriving this cycle competes like a latched one
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            cand[i] = pending_q[i] | core_strobe_i[i];
        end
    end

    // Walk from the far end so the core at rr_ptr_q wins last
    always_comb begin
        core_id_t idx;
        grant_valid = 1'b0;
        grant_id    = rr_ptr_q;
        for (int k = NUM_CORES - 1; k >= 0; k--) begin
            idx = core_id_t'((int'(rr_ptr_q) + k) % NUM_CORES);
            if (cand[idx]) begin
                grant_valid = 1'b1;
                grant_id    = idx;
            end
        end
    end

    assign grant    = (state_q == IDLE) && grant_valid;
    assign next_ptr = core_id_t'((int'(grant_id) + 1) % NUM_CORES);
    assign done     = (state_q == WAIT_DEV) && dev_ready_i;

    // ------------------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            pending_q    <= '0;
            rr_ptr_q     <= '0;
            cur_id_q     <= '0;
            dev_strobe_o <= 1'b0;
        end else begin
            dev_strobe_o <= grant;
            for (int i = 0; i < NUM_CORES; i++) begin
                if (grant && grant_id == core_id_t'(i)) begin
                    pending_q[i] <= 1'b0;
                end else if (core_strobe_i[i]) begin
                    pending_q[i] <= 1'b1;
                end
            end
            case (state_q)
                IDLE: begin
                    if (grant) begin
                        state_q  <= WAIT_DEV;
                        cur_id_q <= grant_id;
                        rr_ptr_q <= next_ptr;
                    end
                end
                WAIT_DEV: begin
                    if (dev_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_CORES; i++) begin
                core_ready_o[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                core_ready_o[i] <= done && (cur_id_q == core_id_t'(i));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Request and response payload
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (core_strobe_i[i]) begin
                req_we_q[i]    <= core_we_i[i];
                req_addr_q[i]  <= core_addr_i[i];
                req_be_q[i]    <= core_be_i[i];
                req_wdata_q[i] <= core_wdata_i[i];
            end
        end
        // Bypass the latch when the winner strobed in this very cycle
        if (grant) begin
            if (core_strobe_i[grant_id]) begin
                dev_we_o    <= core_we_i[grant_id];
                dev_addr_o  <= core_addr_i[grant_id];
                dev_be_o    <= core_be_i[grant_id];
                dev_wdata_o <= core_wdata_i[grant_id];
            end else begin
                dev_we_o    <= req_we_q[grant_id];
                dev_addr_o  <= req_addr_q[grant_id];
                dev_be_o    <= req_be_q[grant_id];
                dev_wdata_o <= req_wdata_q[grant_id];
            end
        end
        if (done) begin
            core_rdata_o[cur_id_q] <= dev_rdata_i;
        end
    end

    // Cores must wait for ready before issuing again
    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core_chk
        a_no_restrobe: assert property (@(posedge clk) disable iff (reset_i)
            core_strobe_i[g] |-> !pending_q[g]);
    end

    a_ready_in_wait: assert property (@(posedge clk) disable iff (reset_i)
        dev_ready_i |-> state_q == WAIT_DEV);

endmodule

//--- devices/intc.sv
`timescale 1ns/1ps

module intc (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           strobe_i,
    input  logic           we_i,
    input  logic [1:0]     reg_sel_i,
    input  soc_pkg::be_t   be_i,
    input  soc_pkg::data_t wdata_i,
    output logic           ready_o,
    output soc_pkg::data_t rdata_o,
    input  soc_pkg::irq_t  irq_src_i,
    output logic           irq_o
);
    import soc_pkg::*;

    irq_t src_q;
    irq_t pending_q;
    irq_t enable_q;
    irq_t rise;
    irq_t clr;
    logic wr;

    assign wr   = strobe_i && we_i && be_i[0];
    assign rise = irq_src_i & ~src_q;
    assign clr  = (wr && reg_sel_i == REG_PENDING) ? wdata_i[IRQ_LINES-1:0] : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            src_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
            ready_o   <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            src_q     <= irq_src_i;
            // A new edge wins over a clear in the same cycle
            pending_q <= (pending_q & ~clr) | rise;
            if (wr && reg_sel_i == REG_ENABLE) begin
                enable_q <= wdata_i[IRQ_LINES-1:0];
            end
            ready_o <= strobe_i;
            irq_o   <= |(pending_q & enable_q);
        end
    end

    // Read data reflects the registers before this access's write
    always_ff @(posedge clk) begin
        if (strobe_i) begin
            case (reg_sel_i)
                REG_PENDING: rdata_o <= data_t'(pending_q);
                REG_ENABLE:  rdata_o <= data_t'(enable_q);
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- devices/uart_console.sv
`timescale 1ns/1ps

module uart_console (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           strobe_i,
    input  logic           we_i,
    input  logic [1:0]     reg_sel_i,
    input  soc_pkg::be_t   be_i,
    input  soc_pkg::data_t wdata_i,
    output logic           ready_o,
    output soc_pkg::data_t rdata_o,
    output logic           tx_valid_o,
    output logic [7:0]     tx_data_o,
    output logic           sim_done_o
);
    import soc_pkg::*;

    logic wr;
    logic tx_wr;

    assign wr    = strobe_i && we_i;
    assign tx_wr = wr && (reg_sel_i == REG_TX) && be_i[0];

    // Status and every other register read back as zero
    assign rdata_o = '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ready_o    <= 1'b0;
            tx_valid_o <= 1'b0;
            sim_done_o <= 1'b0;
        end else begin
            ready_o    <= strobe_i;
            tx_valid_o <= tx_wr;
            // Sticky until reset
            if (wr && reg_sel_i == REG_SIMDONE) begin
                sim_done_o <= 1'b1;
            end
        end
    end

    // Byte lane 0 carries the character
    always_ff @(posedge clk) begin
        if (tx_wr) begin
            tx_data_o <= wdata_i[7:0];
        end
    end

endmodule

//--- common/soc_pkg.sv
package soc_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int NUM_CORES    = 2;
    localparam int CORE_ID_BITS = 1;
    localparam int XLEN         = 32;
    localparam int IRQ_LINES    = 4;

    // Bus vectors
    typedef logic [XLEN-1:0]         addr_t;
    typedef logic [XLEN-1:0]         data_t;
    typedef logic [XLEN/8-1:0]       be_t;
    typedef logic [CORE_ID_BITS-1:0] core_id_t;
    typedef logic [IRQ_LINES-1:0]    irq_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------

    // Address bits 31:30 of a device access
    localparam logic [1:0] IO_WINDOW = 2'b11;

    // Device select in address bits 27:24
    localparam logic [3:0] DEV_UART = 4'h0;
    localparam logic [3:0] DEV_INTC = 4'h4;

    // Console registers, word offset in bits 3:2
    localparam logic [1:0] REG_TX      = 2'd0;
    localparam logic [1:0] REG_STATUS  = 2'd1;
    localparam logic [1:0] REG_SIMDONE = 2'd2;

    // Interrupt controller registers
    localparam logic [1:0] REG_PENDING = 2'd0;
    localparam logic [1:0] REG_ENABLE  = 2'd1;

    // Device arbiter FSM
    typedef enum logic {
        IDLE,
        WAIT_DEV
    } arb_state_t;

endpackage
